// ==== design/dircc_application_pkg.sv ====
`default_nettype none

`include "dircc_params.svh"

package dircc_application_pkg;

    import dircc_types_pkg::*;

    // payload seen as a tick.
    typedef struct packed {
        logic [`DIRCC_PACKET_DATA_WIDTH-1:0] tick;
    } tick_msg_t;

    // layout of device_state_t.user_state.
    typedef struct packed {
        logic [15:0] rts;
        logic [15:0] count;
    } dev_state_t;

    // handed to the host when a device update finishes.
    typedef struct packed {
        dircc_addr_t   address;
        logic [15:0]   rts;
        logic [15:0]   count;
        dircc_state_t  dircc_state;
    } done_event_t;

    // per device time limit.
    function automatic logic [15:0] dircc_max_time(input dircc_addr_t address);
        return 16'(`DIRCC_MAX_TIME_BASE) + 16'(address);
    endfunction

endpackage : dircc_application_pkg

`default_nettype wire

// ==== design/dircc_node_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module dircc_node_controller
    import dircc_types_pkg::*;
    import dircc_application_pkg::*;
(
    input  wire                clk,
    input  wire                reset_n,
    output logic               pkt_pop,
    input  wire packet_data_t  pkt_head,
    input  wire                pkt_empty,
    output packet_data_t       packet,
    output logic               evt_push,
    output done_event_t        evt_data,
    dircc_state_if.controller  state
);

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT
    } ctrl_state_t;

    ctrl_state_t ctrl_q;
    ctrl_state_t ctrl_d;
    dev_state_t  dev_state_new;

    assign pkt_pop            = (ctrl_q == IDLE) && !pkt_empty;
    assign state.address      = packet.address;
    assign state.receive_done = (ctrl_q == ISSUE);

    always_comb begin
        ctrl_d = ctrl_q;
        case (ctrl_q)
            IDLE:    if (!pkt_empty) ctrl_d = ISSUE;
            ISSUE:   ctrl_d = WAIT;
            WAIT:    if (state.packet_handled) ctrl_d = IDLE;
            default: ctrl_d = IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            ctrl_q <= IDLE;
        end else begin
            ctrl_q <= ctrl_d;
        end
    end

    always_ff @(posedge clk) begin
        if (pkt_pop) begin
            packet <= pkt_head;
        end
    end

    // event fields come straight from the handler's registered result.
    assign dev_state_new        = dev_state_t'(state.write_state.user_state);
    assign evt_data.address     = packet.address;
    assign evt_data.rts         = dev_state_new.rts;
    assign evt_data.count       = dev_state_new.count;
    assign evt_data.dircc_state = state.write_state.dircc_state;

    assign evt_push = (ctrl_q == WAIT) && state.packet_handled && state.device_finished;

endmodule : dircc_node_controller

`default_nettype wire

// ==== design/dircc_node_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dircc_node_top
    import dircc_types_pkg::*;
    import dircc_application_pkg::*;
(
    input  wire                clk,
    input  wire                reset_n,
    input  wire packet_data_t  packet_in,
    input  wire                packet_in_valid,
    output logic               packet_in_full,
    output done_event_t        done_event,
    output logic               done_empty,
    input  wire                done_pop
);

    packet_data_t pkt_head;
    packet_data_t packet;
    logic         pkt_pop;
    logic         pkt_empty;
    logic         evt_push;
    done_event_t  evt_data;

    dircc_state_if state_bus ();

    dircc_packet_fifo #(.payload_t(packet_data_t)) pkt_fifo_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .push      (packet_in_valid),
        .push_data (packet_in),
        .pop       (pkt_pop),
        .pop_data  (pkt_head),
        .full      (packet_in_full),
        .empty     (pkt_empty)
    );

    dircc_node_controller ctrl_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .pkt_pop   (pkt_pop),
        .pkt_head  (pkt_head),
        .pkt_empty (pkt_empty),
        .packet    (packet),
        .evt_push  (evt_push),
        .evt_data  (evt_data),
        .state     (state_bus.controller)
    );

    dircc_receive_handler handler_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .packet_in (packet),
        .state     (state_bus.handler)
    );

    dircc_state_store store_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .state     (state_bus.store)
    );

    // a full event queue drops the push.
    dircc_packet_fifo #(.payload_t(done_event_t)) evt_fifo_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .push      (evt_push),
        .push_data (evt_data),
        .pop       (done_pop),
        .pop_data  (done_event),
        .full      (),
        .empty     (done_empty)
    );

endmodule : dircc_node_top

`default_nettype wire

// ==== design/dircc_packet_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dircc_params.svh"

module dircc_packet_fifo #(
    parameter type payload_t = logic [7:0]
) (
    input  wire            clk,
    input  wire            reset_n,
    input  wire            push,
    input  wire payload_t  push_data,
    input  wire            pop,
    output payload_t       pop_data,
    output logic           full,
    output logic           empty
);

    localparam int DEPTH = `DIRCC_FIFO_DEPTH;
    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t mem [DEPTH];

    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [PTR_WIDTH:0]   count;
    logic                 do_push;
    logic                 do_pop;

    assign full  = (count == (PTR_WIDTH+1)'(DEPTH));
    assign empty = (count == '0);

    assign do_push = push && !full;      // overflow is dropped.
    assign do_pop  = pop && !empty;

    assign pop_data = mem[rd_ptr];       // head shows through.

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : dircc_packet_fifo

`default_nettype wire

// ==== design/dircc_params.svh ====
`ifndef DIRCC_PARAMS_SVH
`define DIRCC_PARAMS_SVH

// device addressing.
`define DIRCC_ADDR_WIDTH 3
`define DIRCC_NUM_DEVICES 8

// payload carried by every packet.
`define DIRCC_PACKET_DATA_WIDTH 16

// entries per queue, both packet and event side.
`define DIRCC_FIFO_DEPTH 4

// each device finishes after base + address ticks.
`define DIRCC_MAX_TIME_BASE 3

`endif

// ==== design/dircc_receive_handler.sv ====
`timescale 1ns/1ps
`default_nettype none

module dircc_receive_handler
    import dircc_types_pkg::*;
    import dircc_application_pkg::*;
(
    input  wire                clk,
    input  wire                reset_n,
    input  wire packet_data_t  packet_in,
    dircc_state_if.handler     state
);

    dev_state_t    dev_state_old;
    dev_state_t    dev_state_new;
    dircc_state_t  dircc_state_next;
    logic [15:0]   count_next;
    logic          finish;

    assign dev_state_old = dev_state_t'(state.read_state.user_state);
    assign count_next    = dev_state_old.count + 16'h0001;
    assign finish        = (count_next >= dircc_max_time(packet_in.address));

    always_comb begin
        dev_state_new.count = count_next;
        if (finish) begin
            // rts stays put once the device is done.
            dev_state_new.rts = dev_state_old.rts;
            dircc_state_next  = DIRCC_STATE_DONE |
                ((dev_state_old.rts != '0) ? state.read_state.dircc_state
                                           : DIRCC_STATE_STOPPED);
        end else begin
            dev_state_new.rts = dev_state_old.rts + 16'h0001;
            dircc_state_next  = state.read_state.dircc_state;
        end
    end

    always_ff @(posedge clk) begin
        if (state.receive_done) begin
            state.write_state.dircc_state       <= dircc_state_next;
            state.write_state.dircc_state_extra <= state.read_state.dircc_state_extra;
            state.write_state.user_state        <= dev_state_new;
        end
    end

    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            state.write_state_valid <= 1'b0;
            state.packet_handled    <= 1'b0;
            state.device_finished   <= 1'b0;
        end else begin
            state.write_state_valid <= state.receive_done;
            state.packet_handled    <= state.receive_done;   // same cycle as the write.
            if (state.receive_done) begin
                state.device_finished <= finish;
            end
        end
    end

endmodule : dircc_receive_handler

`default_nettype wire

// ==== design/dircc_state_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface dircc_state_if
    import dircc_types_pkg::*;
();

    dircc_addr_t    address;
    logic           receive_done;        // start strobe from the controller.
    device_state_t  read_state;
    device_state_t  write_state;
    logic           write_state_valid;
    logic           packet_handled;
    logic           device_finished;     // qualifies packet_handled.

    modport controller (
        output address,
        output receive_done,
        input  write_state,
        input  packet_handled,
        input  device_finished
    );

    modport handler (
        input  receive_done,
        input  read_state,
        output write_state,
        output write_state_valid,
        output packet_handled,
        output device_finished
    );

    modport store (
        input  address,
        input  write_state,
        input  write_state_valid,
        output read_state
    );

endinterface : dircc_state_if

`default_nettype wire

// ==== design/dircc_state_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dircc_params.svh"

module dircc_state_store
    import dircc_types_pkg::*;
(
    input  wire  clk,
    input  wire  reset_n,
    dircc_state_if.store state
);

    device_state_t entries [`DIRCC_NUM_DEVICES];

    // read is combinational so the handler sees it in the issue cycle.
    assign state.read_state = entries[state.address];

    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `DIRCC_NUM_DEVICES; i++) begin
                entries[i] <= '0;
            end
        end else if (state.write_state_valid) begin
            entries[state.address] <= state.write_state;   // address still held in wait.
        end
    end

endmodule : dircc_state_store

`default_nettype wire

// ==== design/dircc_types_pkg.sv ====
`default_nettype none

`include "dircc_params.svh"

package dircc_types_pkg;

    typedef logic [`DIRCC_ADDR_WIDTH-1:0] dircc_addr_t;

    // one tick packet as it arrives from the host.
    typedef struct packed {
        dircc_addr_t                          address;
        logic [`DIRCC_PACKET_DATA_WIDTH-1:0]  data;
    } packet_data_t;

    // system state code, DONE is a flag ORed onto another code.
    typedef logic [3:0] dircc_state_t;

    localparam dircc_state_t DIRCC_STATE_RUNNING = 4'd1;
    localparam dircc_state_t DIRCC_STATE_STOPPED = 4'd2;
    localparam dircc_state_t DIRCC_STATE_DONE    = 4'd8;

    // stored per device.
    typedef struct packed {
        dircc_state_t  dircc_state;
        logic [3:0]    dircc_state_extra;
        logic [31:0]   user_state;       // application layout, see dev_state_t.
    } device_state_t;

endpackage : dircc_types_pkg

`default_nettype wire

// ==== list.f ====
+incdir+design
design/dircc_types_pkg.sv
design/dircc_application_pkg.sv
design/dircc_state_if.sv
design/dircc_packet_fifo.sv
design/dircc_state_store.sv
design/dircc_receive_handler.sv
design/dircc_node_controller.sv
design/dircc_node_top.sv
tb/tb_dircc_node.sv

// ==== tb/tb_dircc_node.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dircc_params.svh"

module tb_dircc_node
    import dircc_types_pkg::*;
    import dircc_application_pkg::*;
();

    logic          clk;
    logic          reset_n;
    packet_data_t  packet_in;
    logic          packet_in_valid;
    logic          packet_in_full;
    done_event_t   done_event;
    logic          done_empty;
    logic          done_pop;

    logic [15:0]   model_count [`DIRCC_NUM_DEVICES];
    logic [15:0]   model_rts [`DIRCC_NUM_DEVICES];
    dircc_state_t  model_state [`DIRCC_NUM_DEVICES];
    done_event_t   expected_q [$];
    done_event_t   last_event;
    logic [15:0]   stim_lfsr = 16'd90;
    logic [15:0]   pace_lfsr = 16'd90;   // steps only for the pop pacing.
    int            events_seen = 0;
    int            checks = 0;
    int            errors = 0;
    int            failed_tests = 0;
    int            test_errors = 0;

    dircc_node_top dut_i (
        .clk             (clk),
        .reset_n         (reset_n),
        .packet_in       (packet_in),
        .packet_in_valid (packet_in_valid),
        .packet_in_full  (packet_in_full),
        .done_event      (done_event),
        .done_empty      (done_empty),
        .done_pop        (done_pop)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // taps 16, 14, 13, 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, inout logic [15:0] s, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            s = lfsr_next(s);
            v = {v[14:0], s[0]};         // new bit in at the bottom.
        end
    endtask

    // applies the handler rule to the model table and returns 1 when the device finishes.
    function automatic logic dircc_model_update(input logic [2:0] addr,
                                                output done_event_t evt);
        logic [15:0] count;
        logic [15:0] limit;
        count = model_count[addr] + 16'd1;
        limit = 16'(`DIRCC_MAX_TIME_BASE) + 16'(addr);
        model_count[addr] = count;
        if (count >= limit) begin
            model_state[addr] = DIRCC_STATE_DONE |
                ((model_rts[addr] != 16'd0) ? model_state[addr] : DIRCC_STATE_STOPPED);
        end else begin
            model_rts[addr] = model_rts[addr] + 16'd1;
        end
        evt.address     = addr;
        evt.rts         = model_rts[addr];
        evt.count       = count;
        evt.dircc_state = model_state[addr];
        return (count >= limit);
    endfunction

    task automatic send_tick(input logic [2:0] addr, input logic [15:0] data,
                             input bit stop_if_full, output bit sent);
        int          waited;
        done_event_t evt;
        waited = 0;
        sent = 1'b0;
        @(negedge clk);
        if (!(stop_if_full && packet_in_full)) begin
            while (packet_in_full && waited < 200) begin
                @(negedge clk);
                waited++;
            end
            if (packet_in_full) begin
                $display("packet queue stayed full for %0d cycles at %0t", waited, $time);
                errors++;
            end else begin
                @(posedge clk);
                packet_in.address <= addr;
                packet_in.data    <= data;
                packet_in_valid   <= 1'b1;
                @(posedge clk);
                packet_in_valid   <= 1'b0;
                if (dircc_model_update(addr, evt)) expected_q.push_back(evt);
                sent = 1'b1;
            end
        end
    endtask

    task automatic drain_events();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < 400) begin
            @(negedge clk);
            waited++;
        end
        if (expected_q.size() != 0) begin
            $display("timed out at %0t with %0d events still due", $time, expected_q.size());
            errors++;
        end
        repeat (20) @(negedge clk);      // longer than a full packet queue takes to drain.
    endtask

    task automatic end_test(input int num, input string name);
        if (errors > test_errors) failed_tests++;
        $display("test %0d %s: %s", num, name, (errors > test_errors) ? "failed" : "ok");
        test_errors = errors;
    endtask

    initial begin : event_check
        done_event_t exp;
        logic [15:0] gap;
        done_pop = 1'b0;
        forever begin
            @(negedge clk);
            if (!done_empty) begin
                events_seen++;
                last_event = done_event;
                checks++;
                assert (expected_q.size() != 0) else begin
                    $display("unexpected event from device %0d at %0t",
                             done_event.address, $time);
                    errors++;
                end
                if (expected_q.size() != 0) begin
                    exp = expected_q.pop_front();
                    checks++;
                    assert (done_event == exp) else begin
                        $display("mismatch at %0t: got %0d/%0d/%0d/%h, want %0d/%0d/%0d/%h",
                                 $time, done_event.address, done_event.rts, done_event.count,
                                 done_event.dircc_state, exp.address, exp.rts, exp.count,
                                 exp.dircc_state);
                        errors++;
                    end
                end
                @(posedge clk);
                done_pop <= 1'b1;
                @(posedge clk);
                done_pop <= 1'b0;
                draw_bits(1, pace_lfsr, gap);
                if (gap[0]) @(posedge clk);
            end
        end
    end

    initial begin
        logic [15:0] r_addr;
        logic [15:0] r_data;
        logic [15:0] r_gap;
        bit          sent;
        int          pushed;
        int          seen_before;
        reset_n = 1'b0;
        packet_in = '0;
        packet_in_valid = 1'b0;
        for (int i = 0; i < `DIRCC_NUM_DEVICES; i++) begin
            model_count[i] = '0;
            model_rts[i]   = '0;
            model_state[i] = '0;
        end
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;

        for (int i = 0; i < 50; i++) begin
            @(negedge clk);
            checks++;
            assert (done_empty && !packet_in_full) else begin
                $display("mismatch at %0t: done_empty %b packet_in_full %b while idle",
                         $time, done_empty, packet_in_full);
                errors++;
            end
        end
        end_test(1, "idle after reset");

        seen_before = events_seen;
        for (int i = 0; i < `DIRCC_MAX_TIME_BASE; i++) send_tick(3'd0, 16'(i), 1'b0, sent);
        drain_events();
        checks++;
        assert (events_seen == seen_before + 1 && last_event.count == 16'd3 &&
                last_event.rts == 16'd2 && last_event.dircc_state == DIRCC_STATE_DONE) else begin
            $display("mismatch at %0t: device 0 gave %0d events, last rts %0d count %0d",
                     $time, events_seen - seen_before, last_event.rts, last_event.count);
            errors++;
        end
        end_test(2, "device 0 finish");

        seen_before = events_seen;
        for (int i = 0; i < 11; i++) send_tick(3'd5, 16'(i), 1'b0, sent);
        drain_events();
        checks++;
        assert (events_seen == seen_before + 4 && last_event.count == 16'd11 &&
                last_event.rts == 16'd7) else begin
            $display("mismatch at %0t: device 5 gave %0d events, last rts %0d count %0d",
                     $time, events_seen - seen_before, last_event.rts, last_event.count);
            errors++;
        end
        end_test(3, "device 5 past its limit");

        pushed = 0;
        sent = 1'b1;
        while (sent && pushed < 64) begin
            send_tick(3'd7, 16'(pushed), 1'b1, sent);
            if (sent) pushed++;
        end
        checks++;
        assert (!sent) else begin
            $display("packet queue never reported full after %0d pushes", pushed);
            errors++;
        end
        for (int i = 0; i < 2 || model_count[7] < 16'(`DIRCC_MAX_TIME_BASE + 7); i++) begin
            send_tick(3'd7, 16'hbeef, 1'b0, sent);
            if (sent) pushed++;
        end
        drain_events();
        checks++;
        assert (last_event.address == 3'd7 && last_event.count == 16'(pushed)) else begin
            $display("mismatch at %0t: device 7 count %0d after %0d ticks",
                     $time, last_event.count, pushed);
            errors++;
        end
        end_test(4, "fill packet queue");

        for (int i = 0; i < 200; i++) begin
            draw_bits(3, stim_lfsr, r_addr);
            draw_bits(16, stim_lfsr, r_data);
            draw_bits(2, stim_lfsr, r_gap);
            send_tick(r_addr[2:0], r_data, 1'b0, sent);
            repeat (r_gap[1:0]) @(posedge clk);
        end
        drain_events();
        end_test(5, "random traffic");

        $display("5 tests, %0d failed, %0d checks, %0d errors", failed_tests, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule : tb_dircc_node

`default_nettype wire
